//--- rtl/mmu_pkg.sv
/*
 * shared definitions of the memory management unit
 * TLB sizes, page and entry structs, the TLB write strobe and lookup result,
 * memory command, exception code and access state enums,
 * and a helper that classifies store commands
 */

package mmu_pkg;

	// TLB geometry
	localparam int tlb_nr_entry = 8;
	localparam int tlb_index_width = 3;

	// address field widths
	localparam int vpn2_width = 19;
	localparam int pfn_width = 20;
	localparam int page_offset_width = 12;

	// top nibble range of the direct-mapped window
	localparam logic [3:0] window_lo = 4'h8;
	localparam logic [3:0] window_hi = 4'hb;

	// one half of a TLB entry, dirty means writable
	typedef struct packed {
		logic [pfn_width-1:0] pfn;
		logic dirty;
		logic valid;
	} tlb_page_t;

	// odd page sits above the even page
	typedef struct packed {
		logic [vpn2_width-1:0] vpn2;
		tlb_page_t odd;
		tlb_page_t even;
	} tlb_entry_t;

	typedef struct packed {
		logic enable;
		logic [tlb_index_width-1:0] index;
		tlb_entry_t entry;
	} tlb_write_t;

	typedef struct packed {
		logic hit;
		logic writable;
		logic [31:0] paddr;
	} tlb_result_t;

	typedef enum logic [2:0] {
		mem_opt_none = 3'd0,
		mem_opt_lw = 3'd1,
		mem_opt_lbs = 3'd2,
		mem_opt_lbu = 3'd3,
		mem_opt_sb = 3'd4,
		mem_opt_sw = 3'd5
	} mem_opt_e;

	// MIPS cause register codes
	typedef enum logic [4:0] {
		exc_none = 5'd0,
		exc_tlb_mod = 5'd1,
		exc_tlbl = 5'd2,
		exc_tlbs = 5'd3,
		exc_adel = 5'd4,
		exc_ades = 5'd5
	} exc_code_e;

	typedef enum logic [1:0] {
		state_idle = 2'd0,
		state_merge_byte = 2'd1,
		state_do_write = 2'd2
	} access_state_e;

	function automatic logic mem_opt_is_write(input mem_opt_e opt);
		return opt == mem_opt_sb || opt == mem_opt_sw;
	endfunction

endpackage

//--- rtl/tlb_slot.sv
/*
 * single TLB slot
 * holds one even/odd page pair, loads it from the write strobe
 * when addressed, and reports a hit on the even or odd page
 */

`timescale 1ns/100ps

module tlb_slot #(
	parameter int unsigned slot_index = 0
) (
	input logic clk,
	input logic rst,
	input mmu_pkg::tlb_write_t tlb_write,
	input logic [31:0] vaddr,
	output logic hit_even,
	output logic hit_odd,
	output mmu_pkg::tlb_entry_t entry
);

	localparam logic [mmu_pkg::tlb_index_width-1:0] my_index =
		slot_index[mmu_pkg::tlb_index_width-1:0];

	logic write_here;
	logic vpn_match;
	logic odd_page;

	// write decode for this slot only
	assign write_here = tlb_write.enable && tlb_write.index == my_index;

	// entry is cleared on reset so nothing matches until software loads it
	always_ff @(posedge clk) begin
		if (rst) begin
			entry <= '0;
		end else if (write_here) begin
			entry <= tlb_write.entry;
		end
	end

	// vpn2 covers a pair of 4 KB pages
	assign vpn_match = entry.vpn2 == vaddr[31:32-mmu_pkg::vpn2_width];

	// bit 12 picks the odd page of the pair
	assign odd_page = vaddr[mmu_pkg::page_offset_width];

	assign hit_even = vpn_match && !odd_page && entry.even.valid;
	assign hit_odd = vpn_match && odd_page && entry.odd.valid;

endmodule

//--- rtl/tlb_merge.sv
/*
 * TLB result merge
 * folds the per-slot hits into one frame number and dirty bit,
 * adds the direct-mapped window and forms the physical address
 */

`timescale 1ns/100ps

module tlb_merge (
	input logic [31:0] vaddr,
	input logic [mmu_pkg::tlb_nr_entry-1:0] hit_even,
	input logic [mmu_pkg::tlb_nr_entry-1:0] hit_odd,
	input mmu_pkg::tlb_entry_t entries [0:mmu_pkg::tlb_nr_entry-1],
	output mmu_pkg::tlb_result_t result
);

	logic [mmu_pkg::pfn_width-1:0] sel_pfn;
	logic sel_dirty;
	logic mapped_hit;
	logic window_hit;

	// at most one page hits, so an OR of the masked fields selects it
	always_comb begin
		sel_pfn = '0;
		sel_dirty = 1'b0;
		for (int i = 0; i < mmu_pkg::tlb_nr_entry; i++) begin
			sel_pfn = sel_pfn
				| ({mmu_pkg::pfn_width{hit_even[i]}} & entries[i].even.pfn)
				| ({mmu_pkg::pfn_width{hit_odd[i]}} & entries[i].odd.pfn);
			sel_dirty = sel_dirty
				| (hit_even[i] & entries[i].even.dirty)
				| (hit_odd[i] & entries[i].odd.dirty);
		end
	end

	assign mapped_hit = |{hit_even, hit_odd};

	// 0x80000000 to 0xbfffffff bypasses the TLB
	assign window_hit = vaddr[31:28] >= mmu_pkg::window_lo
		&& vaddr[31:28] <= mmu_pkg::window_hi;

	always_comb begin
		result.hit = window_hit || mapped_hit;
		result.writable = window_hit || sel_dirty;
		if (window_hit) begin
			result.paddr = {3'b000, vaddr[28:0]};
		end else begin
			result.paddr = {sel_pfn, vaddr[mmu_pkg::page_offset_width-1:0]};
		end
	end

endmodule

//--- rtl/mmu_access.sv
/*
 * MMU access controller
 * virtual address selection, exception resolution, load byte extraction,
 * busy generation and the store state machine that drives the
 * physical memory write, including the read-modify-write for byte stores
 */

`timescale 1ns/100ps

module mmu_access (
	input logic clk,
	input logic rst,

	input logic [31:0] instr_addr,
	output logic [31:0] instr_out,

	input mmu_pkg::mem_opt_e data_opt,
	input logic [31:0] data_addr,
	input logic [31:0] data_in,
	output logic [31:0] data_out,
	output logic busy,
	output mmu_pkg::exc_code_e exc_code,

	output logic [31:0] vaddr,
	input mmu_pkg::tlb_result_t tlb_result,

	input logic [31:0] dev_mem_data_in,
	output logic [31:0] dev_mem_data_out,
	output logic dev_mem_is_write,
	input logic dev_mem_busy
);

	mmu_pkg::access_state_e state;

	logic is_write;
	logic fetch_sel;
	logic [31:0] raw_addr;
	logic [1:0] lane;
	logic [7:0] lane_byte;
	logic accept;

	assign is_write = mmu_pkg::mem_opt_is_write(data_opt);

	// fetch uses the port only while idle and no data command is pending
	assign fetch_sel = state == mmu_pkg::state_idle && data_opt == mmu_pkg::mem_opt_none;
	assign raw_addr = fetch_sel ? instr_addr : data_addr;
	assign lane = raw_addr[1:0];

	// the TLB always sees a word address
	assign vaddr = {raw_addr[31:2], 2'b00};

	// instruction word comes straight from memory
	assign instr_out = dev_mem_data_in;

	// later checks override earlier ones
	always_comb begin
		exc_code = mmu_pkg::exc_none;
		if (lane != 2'b00) begin
			if (state == mmu_pkg::state_idle
					&& (data_opt == mmu_pkg::mem_opt_lw
					|| data_opt == mmu_pkg::mem_opt_none)) begin
				exc_code = mmu_pkg::exc_adel;
			end
			if (data_opt == mmu_pkg::mem_opt_sw) begin
				exc_code = mmu_pkg::exc_ades;
			end
		end
		if (!tlb_result.hit) begin
			if (is_write) begin
				exc_code = mmu_pkg::exc_tlbs;
			end else begin
				exc_code = mmu_pkg::exc_tlbl;
			end
		end else if (!tlb_result.writable && is_write) begin
			exc_code = mmu_pkg::exc_tlb_mod;
		end
	end

	// stores always take extra cycles, loads only under memory back-pressure
	assign busy = (state != mmu_pkg::state_idle || dev_mem_busy || is_write)
		&& exc_code == mmu_pkg::exc_none;

	// byte lane of the memory word
	always_comb begin
		case (lane)
			2'd0: lane_byte = dev_mem_data_in[7:0];
			2'd1: lane_byte = dev_mem_data_in[15:8];
			2'd2: lane_byte = dev_mem_data_in[23:16];
			default: lane_byte = dev_mem_data_in[31:24];
		endcase
	end

	always_comb begin
		case (data_opt)
			mmu_pkg::mem_opt_lw: data_out = dev_mem_data_in;
			mmu_pkg::mem_opt_lbs: data_out = {{24{lane_byte[7]}}, lane_byte};
			mmu_pkg::mem_opt_lbu: data_out = {24'h000000, lane_byte};
			default: data_out = 32'h00000000;
		endcase
	end

	// a command is taken once memory is free and no exception blocks it
	assign accept = state == mmu_pkg::state_idle && !dev_mem_busy
		&& data_opt != mmu_pkg::mem_opt_none && exc_code == mmu_pkg::exc_none;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mmu_pkg::state_idle;
		end else begin
			case (state)
				mmu_pkg::state_idle: begin
					if (accept && data_opt == mmu_pkg::mem_opt_sb) begin
						state <= mmu_pkg::state_merge_byte;
					end else if (accept && data_opt == mmu_pkg::mem_opt_sw) begin
						state <= mmu_pkg::state_do_write;
					end
				end
				mmu_pkg::state_merge_byte: state <= mmu_pkg::state_do_write;
				mmu_pkg::state_do_write: state <= mmu_pkg::state_idle;
				default: state <= mmu_pkg::state_idle;
			endcase
		end
	end

	// write data register
	// the new byte rides in bits 7:0 until the old word is read back
	always_ff @(posedge clk) begin
		if (accept) begin
			dev_mem_data_out <= data_in;
		end else if (state == mmu_pkg::state_merge_byte) begin
			case (lane)
				2'd0: dev_mem_data_out <= {dev_mem_data_in[31:8], dev_mem_data_out[7:0]};
				2'd1: dev_mem_data_out <= {dev_mem_data_in[31:16], dev_mem_data_out[7:0],
					dev_mem_data_in[7:0]};
				2'd2: dev_mem_data_out <= {dev_mem_data_in[31:24], dev_mem_data_out[7:0],
					dev_mem_data_in[15:0]};
				default: dev_mem_data_out <= {dev_mem_data_out[7:0], dev_mem_data_in[23:0]};
			endcase
		end
	end

	assign dev_mem_is_write = state == mmu_pkg::state_do_write;

endmodule

//--- rtl/mmu.sv
/*
 * memory management unit top level
 * access controller, array of TLB slots and the result merge
 */

`timescale 1ns/100ps

module mmu (
	input logic clk,
	input logic rst,

	input mmu_pkg::tlb_write_t tlb_write,

	input logic [31:0] instr_addr,
	output logic [31:0] instr_out,

	input mmu_pkg::mem_opt_e data_opt,
	input logic [31:0] data_addr,
	input logic [31:0] data_in,
	output logic [31:0] data_out,
	output logic busy,
	output mmu_pkg::exc_code_e exc_code,

	// physical memory port
	output logic [31:0] dev_mem_addr,
	input logic [31:0] dev_mem_data_in,
	output logic [31:0] dev_mem_data_out,
	output logic dev_mem_is_write,
	input logic dev_mem_busy
);

	logic [31:0] vaddr;
	mmu_pkg::tlb_result_t tlb_result;
	logic [mmu_pkg::tlb_nr_entry-1:0] hit_even;
	logic [mmu_pkg::tlb_nr_entry-1:0] hit_odd;
	mmu_pkg::tlb_entry_t entries [0:mmu_pkg::tlb_nr_entry-1];

	mmu_access u_access (
		.clk(clk),
		.rst(rst),
		.instr_addr(instr_addr),
		.instr_out(instr_out),
		.data_opt(data_opt),
		.data_addr(data_addr),
		.data_in(data_in),
		.data_out(data_out),
		.busy(busy),
		.exc_code(exc_code),
		.vaddr(vaddr),
		.tlb_result(tlb_result),
		.dev_mem_data_in(dev_mem_data_in),
		.dev_mem_data_out(dev_mem_data_out),
		.dev_mem_is_write(dev_mem_is_write),
		.dev_mem_busy(dev_mem_busy)
	);

	// every slot sees the same write strobe and picks out its own index
	for (genvar i = 0; i < mmu_pkg::tlb_nr_entry; i++) begin : g_slot
		tlb_slot #(
			.slot_index(i)
		) u_slot (
			.clk(clk),
			.rst(rst),
			.tlb_write(tlb_write),
			.vaddr(vaddr),
			.hit_even(hit_even[i]),
			.hit_odd(hit_odd[i]),
			.entry(entries[i])
		);
	end

	tlb_merge u_merge (
		.vaddr(vaddr),
		.hit_even(hit_even),
		.hit_odd(hit_odd),
		.entries(entries),
		.result(tlb_result)
	);

	assign dev_mem_addr = tlb_result.paddr;

endmodule

//--- test/mmu_checker.sv
/*
 * MMU checker
 * shadow TLB and memory, reference model of translation and loads,
 * per-cycle comparison of the DUT ports and error counts
 */

`timescale 1ns/100ps

module mmu_checker (
	input logic clk,
	input logic rst,
	input logic [2:0] test_id,
	input mmu_pkg::tlb_write_t tlb_write,
	input logic [31:0] instr_addr,
	input logic [31:0] instr_out,
	input mmu_pkg::mem_opt_e data_opt,
	input logic [31:0] data_addr,
	input logic [31:0] data_in,
	input logic [31:0] data_out,
	input logic busy,
	input mmu_pkg::exc_code_e exc_code,
	input logic [31:0] dev_mem_addr,
	input logic [31:0] dev_mem_data_out,
	input logic dev_mem_is_write,
	input logic dev_mem_busy,
	output int value_errors,
	output int protocol_errors
);

	mmu_pkg::tlb_entry_t tlb_shadow [0:mmu_pkg::tlb_nr_entry-1];
	logic [31:0] mem_shadow [0:4095];

	// store between acceptance and its memory write
	int write_wait;
	logic [31:0] write_addr;
	logic [31:0] write_word;

	function automatic logic [31:0] fill_word(input int idx);
		return {idx[11:0], 4'ha, ~idx[11:0], 4'h5};
	endfunction

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1: return "direct_mapped";
			3'd2: return "mapped";
			3'd3: return "stores";
			3'd4: return "exceptions";
			3'd5: return "back_pressure";
			3'd6: return "reset";
			default: return "startup";
		endcase
	endfunction

	task automatic value_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERROR %s %s: expected %h actual %h", test_name(test_id), what, exp, act);
		value_errors++;
	endtask

	task automatic protocol_fault(input string msg);
		$display("%s: %s at %0t", test_name(test_id), msg, $time);
		protocol_errors++;
	endtask

	// expected exception, physical address and load data of one access
	function automatic void expected_access(input mmu_pkg::mem_opt_e opt,
			input logic [31:0] addr, output mmu_pkg::exc_code_e exc,
			output logic [31:0] paddr, output logic [31:0] rdata);
		logic hit;
		logic writable;
		logic store;
		logic [31:0] word;
		logic [31:0] shifted;
		mmu_pkg::tlb_page_t page;
		hit = 1'b0;
		writable = 1'b0;
		paddr = 32'h0;
		store = opt == mmu_pkg::mem_opt_sb || opt == mmu_pkg::mem_opt_sw;
		if (addr[31:30] == 2'b10) begin
			// unmapped window
			hit = 1'b1;
			writable = 1'b1;
			paddr = {3'b000, addr[28:2], 2'b00};
		end else begin
			for (int i = 0; i < mmu_pkg::tlb_nr_entry; i++) begin
				page = addr[12] ? tlb_shadow[i[2:0]].odd : tlb_shadow[i[2:0]].even;
				if (!hit && page.valid && tlb_shadow[i[2:0]].vpn2 == addr[31:13]) begin
					hit = 1'b1;
					writable = page.dirty;
					paddr = {page.pfn, addr[11:2], 2'b00};
				end
			end
		end
		exc = mmu_pkg::exc_none;
		if (addr[1:0] != 2'b00 && (opt == mmu_pkg::mem_opt_lw || opt == mmu_pkg::mem_opt_none))
			exc = mmu_pkg::exc_adel;
		if (addr[1:0] != 2'b00 && opt == mmu_pkg::mem_opt_sw)
			exc = mmu_pkg::exc_ades;
		if (!hit)
			exc = store ? mmu_pkg::exc_tlbs : mmu_pkg::exc_tlbl;
		else if (store && !writable)
			exc = mmu_pkg::exc_tlb_mod;
		word = mem_shadow[paddr[13:2]];
		shifted = word >> {addr[1:0], 3'b000};
		case (opt)
			mmu_pkg::mem_opt_lw: rdata = word;
			mmu_pkg::mem_opt_lbs: rdata = {{24{shifted[7]}}, shifted[7:0]};
			mmu_pkg::mem_opt_lbu: rdata = {24'h000000, shifted[7:0]};
			default: rdata = 32'h0;
		endcase
	endfunction

	always @(posedge clk) begin : compare
		mmu_pkg::exc_code_e exp_exc;
		logic [31:0] exp_paddr;
		logic [31:0] exp_data;
		logic [31:0] old_word;
		logic [4:0] sh;
		logic is_store;
		logic exp_busy;
		if (rst) begin
			for (int i = 0; i < mmu_pkg::tlb_nr_entry; i++) tlb_shadow[i[2:0]] = '0;
			for (int i = 0; i < 4096; i++) mem_shadow[i[11:0]] = fill_word(i);
			write_wait = 0;
			value_errors = 0;
			protocol_errors = 0;
		end else if (write_wait > 0) begin
			if (!busy) value_mismatch("busy during store", 32'h1, 32'h0);
			if (write_wait == 1) begin
				if (!dev_mem_is_write) begin
					protocol_fault("store ended without a memory write");
				end else begin
					if (dev_mem_addr != write_addr)
						value_mismatch("write address", write_addr, dev_mem_addr);
					if (dev_mem_data_out != write_word)
						value_mismatch("write data", write_word, dev_mem_data_out);
				end
				mem_shadow[write_addr[13:2]] = write_word;
			end else if (dev_mem_is_write) begin
				protocol_fault("memory written before the byte merge");
			end
			write_wait--;
		end else begin
			if (dev_mem_is_write) protocol_fault("memory written with no accepted store");
			if (data_opt == mmu_pkg::mem_opt_none)
				expected_access(data_opt, instr_addr, exp_exc, exp_paddr, exp_data);
			else
				expected_access(data_opt, data_addr, exp_exc, exp_paddr, exp_data);
			is_store = data_opt == mmu_pkg::mem_opt_sb || data_opt == mmu_pkg::mem_opt_sw;
			exp_busy = exp_exc == mmu_pkg::exc_none && (dev_mem_busy || is_store);
			if (exc_code != exp_exc) value_mismatch("exc_code", 32'(exp_exc), 32'(exc_code));
			if (busy != exp_busy) value_mismatch("busy", 32'(exp_busy), 32'(busy));
			if (exp_exc == mmu_pkg::exc_none && !exp_busy) begin
				if (dev_mem_addr != exp_paddr)
					value_mismatch("physical address", exp_paddr, dev_mem_addr);
				if (data_opt == mmu_pkg::mem_opt_none && instr_out != mem_shadow[exp_paddr[13:2]])
					value_mismatch("instr_out", mem_shadow[exp_paddr[13:2]], instr_out);
				if (data_opt != mmu_pkg::mem_opt_none && data_out != exp_data)
					value_mismatch("data_out", exp_data, data_out);
			end
			// accepted store, byte stores keep the other three lanes
			if (is_store && exp_exc == mmu_pkg::exc_none && !dev_mem_busy) begin
				old_word = mem_shadow[exp_paddr[13:2]];
				sh = {data_addr[1:0], 3'b000};
				write_addr = exp_paddr;
				write_wait = data_opt == mmu_pkg::mem_opt_sw ? 1 : 2;
				if (data_opt == mmu_pkg::mem_opt_sw)
					write_word = data_in;
				else
					write_word = (old_word & ~(32'hff << sh)) | ({24'h0, data_in[7:0]} << sh);
			end
		end
		if (!rst && tlb_write.enable) tlb_shadow[tlb_write.index] = tlb_write.entry;
	end

endmodule

//--- test/mmu_tb.sv
/*
 * MMU testbench top
 * clock, reset, physical memory model, checker instance,
 * seeded access sequence and run limit
 */

`timescale 1ns/100ps

module mmu_tb;

	localparam int max_stall = 4;
	// accesses, fetches and TLB writes over the six tests
	localparam int op_count = 84;
	// each operation is bounded by its stall plus a byte store sequence
	localparam int cycle_limit = 2 * (4 + op_count * (max_stall + 5));

	logic clk = 1'b0;
	logic rst;
	mmu_pkg::tlb_write_t tlb_write;
	logic [31:0] instr_addr;
	logic [31:0] instr_out;
	mmu_pkg::mem_opt_e data_opt;
	logic [31:0] data_addr;
	logic [31:0] data_in;
	logic [31:0] data_out;
	logic busy;
	mmu_pkg::exc_code_e exc_code;
	logic [31:0] dev_mem_addr;
	logic [31:0] dev_mem_data_in;
	logic [31:0] dev_mem_data_out;
	logic dev_mem_is_write;
	logic dev_mem_busy;
	logic [2:0] test_id;
	int value_errors;
	int protocol_errors;
	int cycle_count = 0;
	logic [31:0] phys_mem [0:4095];

	always #4 clk = ~clk;

	mmu UUT (.*);

	mmu_checker u_checker (.*);

	function automatic logic [31:0] fill_word(input int idx);
		return {idx[11:0], 4'ha, ~idx[11:0], 4'h5};
	endfunction

	function automatic mmu_pkg::tlb_page_t make_page(input logic [19:0] pfn,
			input logic dirty, input logic valid);
		return {pfn, dirty, valid};
	endfunction

	// word-addressed memory with a combinational read
	assign dev_mem_data_in = phys_mem[dev_mem_addr[13:2]];

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4096; i++) phys_mem[i[11:0]] <= fill_word(i);
		end else if (dev_mem_is_write) begin
			phys_mem[dev_mem_addr[13:2]] <= dev_mem_data_out;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycle_count);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic load_tlb(input logic [2:0] index, input logic [18:0] vpn2,
			input mmu_pkg::tlb_page_t even, input mmu_pkg::tlb_page_t odd);
		@(negedge clk);
		tlb_write = {1'b1, index, vpn2, odd, even};
		@(negedge clk);
		tlb_write.enable = 1'b0;
	endtask

	task automatic fetch(input logic [31:0] addr);
		@(negedge clk);
		instr_addr = addr;
		@(posedge clk);
	endtask

	// one data command held until busy falls or the store is taken
	task automatic access(input mmu_pkg::mem_opt_e opt, input logic [31:0] addr,
			input int stall);
		int left;
		logic done;
		left = stall;
		done = 1'b0;
		@(negedge clk);
		data_opt = opt;
		data_addr = addr;
		data_in = $urandom;
		dev_mem_busy = left > 0;
		while (!done) begin
			@(posedge clk);
			if (!busy) begin
				done = 1'b1;
			end else if (!dev_mem_busy
					&& (opt == mmu_pkg::mem_opt_sb || opt == mmu_pkg::mem_opt_sw)) begin
				// the store is taken at this edge so the command strobe drops
				@(negedge clk);
				data_opt = mmu_pkg::mem_opt_none;
				@(posedge clk);
				while (busy) @(posedge clk);
				done = 1'b1;
			end else begin
				@(negedge clk);
				if (left > 0) left--;
				dev_mem_busy = left > 0;
			end
		end
		@(negedge clk);
		data_opt = mmu_pkg::mem_opt_none;
	endtask

	initial begin
		logic [31:0] base;
		logic [31:0] addr;
		logic [1:0] lane;
		mmu_pkg::mem_opt_e opt;
		void'($urandom(32'hc317183f));
		rst = 1'b1;
		tlb_write = '0;
		instr_addr = 32'h80000000;
		data_opt = mmu_pkg::mem_opt_none;
		data_addr = 32'h0;
		data_in = 32'h0;
		dev_mem_busy = 1'b0;
		test_id = 3'd0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// empty TLB right after reset
		test_id = 3'd6;
		access(mmu_pkg::mem_opt_lw, 32'h00400000, 0);
		access(mmu_pkg::mem_opt_sw, 32'h00400000, 0);
		fetch(32'h00400000);
		fetch(32'h80000000);

		test_id = 3'd1;
		for (int k = 0; k < 4; k++) begin
			base = 32'h80000040 + k * 32'h10001100;
			fetch(base);
			access(mmu_pkg::mem_opt_lw, base, 0);
			for (int l = 0; l < 4; l++) begin
				access(mmu_pkg::mem_opt_lbs, base + l, 0);
				access(mmu_pkg::mem_opt_lbu, base + l, 0);
			end
		end

		// slot 2 has both halves invalid
		test_id = 3'd2;
		load_tlb(3'd0, 19'h00200, make_page(20'h00001, 1'b1, 1'b1),
			make_page(20'h00002, 1'b0, 1'b1));
		load_tlb(3'd5, 19'h3f800, make_page(20'h00004, 1'b1, 1'b0),
			make_page(20'h00003, 1'b1, 1'b1));
		load_tlb(3'd2, 19'h00040, make_page(20'h00005, 1'b0, 1'b0),
			make_page(20'h00006, 1'b1, 1'b0));
		access(mmu_pkg::mem_opt_lw, 32'h00400010, 0);
		access(mmu_pkg::mem_opt_lw, 32'h00401020, 0);
		access(mmu_pkg::mem_opt_lbu, 32'h00401023, 0);
		access(mmu_pkg::mem_opt_lw, 32'h7f000000, 0);
		access(mmu_pkg::mem_opt_lbs, 32'h7f001005, 0);
		access(mmu_pkg::mem_opt_lw, 32'h00081000, 0);
		fetch(32'h00401000);
		fetch(32'h00400ffc);

		test_id = 3'd3;
		access(mmu_pkg::mem_opt_sw, 32'h80000300, 0);
		access(mmu_pkg::mem_opt_lw, 32'h80000300, 0);
		lane = 2'($urandom);
		access(mmu_pkg::mem_opt_sb, 32'h80000304 + {30'h0, lane}, 0);
		access(mmu_pkg::mem_opt_lw, 32'h80000304, 0);
		access(mmu_pkg::mem_opt_sw, 32'h00400080, 0);
		access(mmu_pkg::mem_opt_lw, 32'h00400080, 0);
		lane = 2'($urandom);
		access(mmu_pkg::mem_opt_sb, 32'h7f0010a0 + {30'h0, lane}, 0);
		access(mmu_pkg::mem_opt_lw, 32'h7f0010a0, 0);

		// the closing loads show memory untouched
		test_id = 3'd4;
		access(mmu_pkg::mem_opt_lw, 32'h80000002, 0);
		fetch(32'h80000001);
		access(mmu_pkg::mem_opt_sw, 32'h80000302, 0);
		access(mmu_pkg::mem_opt_sw, 32'h00800000, 0);
		access(mmu_pkg::mem_opt_sw, 32'h00401000, 0);
		access(mmu_pkg::mem_opt_sb, 32'h00401003, 0);
		access(mmu_pkg::mem_opt_lw, 32'h80000300, 0);
		access(mmu_pkg::mem_opt_lw, 32'h00401000, 0);
		fetch(32'h80000000);

		test_id = 3'd5;
		for (int n = 0; n < 12; n++) begin
			case ($urandom % 5)
				0: opt = mmu_pkg::mem_opt_lw;
				1: opt = mmu_pkg::mem_opt_lbs;
				2: opt = mmu_pkg::mem_opt_lbu;
				3: opt = mmu_pkg::mem_opt_sb;
				default: opt = mmu_pkg::mem_opt_sw;
			endcase
			addr = ($urandom % 2 == 0) ? 32'h80000400 : 32'h00400200;
			addr[4:2] = 3'($urandom);
			if (opt != mmu_pkg::mem_opt_lw && opt != mmu_pkg::mem_opt_sw) begin
				addr[1:0] = 2'($urandom);
			end
			access(opt, addr, 1 + ($urandom % max_stall));
		end

		repeat (2) @(posedge clk);
		$display("checks done: %0d value errors, %0d protocol errors",
			value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- mmu.f
rtl/mmu_pkg.sv
rtl/tlb_slot.sv
rtl/tlb_merge.sv
rtl/mmu_access.sv
rtl/mmu.sv
test/mmu_checker.sv
test/mmu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the MMU testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module mmu_tb -f mmu.f -Mdir obj_dir -o mmu_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/mmu_sim > sim.log 2>&1
cat sim.log
grep -q "^SIMULATION PASSED$" sim.log && exit 0 || exit 1
